// File: spw_pkg.sv
package spw_pkg;

	// ------------------------------
	// Character geometry
	// ------------------------------
	localparam int DATA_BODY_BITS = 8;
	localparam int CTRL_BODY_BITS = 2;

	// Receive FIFO sizing
	localparam int FIFO_ADDR_BITS = 3;
	localparam int FIFO_DEPTH     = 1 << FIFO_ADDR_BITS;

	// Data field of queued end markers
	localparam logic [DATA_BODY_BITS-1:0] EOP_DATA = 8'h00;
	localparam logic [DATA_BODY_BITS-1:0] EEP_DATA = 8'h01;

	typedef enum logic [2:0] {
		CHAR_DATA = 3'd0,
		CHAR_EOP  = 3'd1,
		CHAR_EEP  = 3'd2,
		CHAR_FCT  = 3'd3,
		CHAR_NULL = 3'd4,
		CHAR_TIME = 3'd5
	} char_kind_e;

	// Two control bits, LSB first on the line
	typedef enum logic [1:0] {
		CTRL_FCT = 2'd0,
		CTRL_EOP = 2'd1,
		CTRL_EEP = 2'd2,
		CTRL_ESC = 2'd3
	} ctrl_code_e;

	typedef struct packed {
		logic                      ctrl;
		logic [DATA_BODY_BITS-1:0] data;
	} fifo_word_t;

endpackage

// File: rx_regs_pkg.sv
package rx_regs_pkg;

	// ------------------------------
	// Wishbone geometry
	// ------------------------------
	localparam int WB_ADR_BITS  = 2;
	localparam int WB_DATA_BITS = 32;

	typedef logic [WB_DATA_BITS-1:0] wb_data_t;

	// Word addresses
	typedef enum logic [WB_ADR_BITS-1:0] {
		REG_STATUS = 2'd0,
		REG_DATA   = 2'd1,
		REG_TIME   = 2'd2,
		REG_FCT    = 2'd3
	} reg_addr_e;

	// ------------------------------
	// Status register bits
	// ------------------------------
	localparam int ST_EMPTY      = 0;
	localparam int ST_GOT_NULL   = 1;
	localparam int ST_PARITY_ERR = 2;
	localparam int ST_ESC_ERR    = 3;
	localparam int ST_OVERFLOW   = 4;
	localparam int ST_TICK       = 5;

	// FIFO empty indication in the data register
	localparam int DATA_EMPTY_BIT = 31;

endpackage

// File: spw_char_if.sv
`timescale 1ns/10ps

interface spw_char_if;

	// One-cycle strobe, no handshake back
	logic                               valid;
	spw_pkg::char_kind_e                kind;
	logic [spw_pkg::DATA_BODY_BITS-1:0] data;
	logic                               parity_err;

	modport dec (
		output valid,
		output kind,
		output data,
		output parity_err
	);

	// Sinks must consume in the valid cycle
	modport sink (
		input valid,
		input kind,
		input data,
		input parity_err
	);

endinterface

// File: spw_ds_bit_recovery.sv
`timescale 1ns/10ps

module spw_ds_bit_recovery (
	input  logic negedge_clk,
	input  logic rx_resetn,
	input  logic rx_din,
	input  logic rx_sin,
	output logic bit_valid,
	output logic bit_value
);

	logic d_meta;
	logic d_sync;
	logic s_meta;
	logic s_sync;
	logic ds_xor_r;
	logic ds_xor;

	// Data XOR strobe flips once per bit
	assign ds_xor = d_sync ^ s_sync;

	// ------------------------------
	// Synchronisers and edge detect
	// ------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			d_meta    <= 1'b0;
			d_sync    <= 1'b0;
			s_meta    <= 1'b0;
			s_sync    <= 1'b0;
			ds_xor_r  <= 1'b0;
			bit_valid <= 1'b0;
			bit_value <= 1'b0;
		end
		else
		begin
			d_meta    <= rx_din;
			d_sync    <= d_meta;
			s_meta    <= rx_sin;
			s_sync    <= s_meta;
			ds_xor_r  <= ds_xor;
			// Pulse once per change, data sampled alongside
			bit_valid <= ds_xor ^ ds_xor_r;
			bit_value <= d_sync;
		end
	end

endmodule

// File: spw_char_decoder.sv
`timescale 1ns/10ps

module spw_char_decoder (
	input  logic    negedge_clk,
	input  logic    rx_resetn,
	input  logic    bit_valid,
	input  logic    bit_value,
	output logic    esc_err,
	spw_char_if.dec chr
);

	typedef enum logic [1:0] {
		DEC_PARITY,
		DEC_FLAG,
		DEC_BODY
	} dec_state_e;

	dec_state_e                         state;
	logic [2:0]                         bit_cnt;
	logic                               par_bit;
	logic                               flag_bit;
	logic [spw_pkg::DATA_BODY_BITS-1:0] body;
	logic [spw_pkg::DATA_BODY_BITS-1:0] body_next;
	logic [spw_pkg::DATA_BODY_BITS-1:0] prev_body;
	logic                               first_char;
	logic                               esc_pend;
	logic                               perr_hold;
	logic                               last_bit;
	logic                               char_done;
	logic                               parity_bad;
	spw_pkg::ctrl_code_e                ctrl_code;

	// Body with the incoming bit merged in
	always_comb
	begin
		body_next          = body;
		body_next[bit_cnt] = bit_value;
	end

	assign last_bit = flag_bit ? (bit_cnt == 3'(spw_pkg::CTRL_BODY_BITS - 1))
	                           : (bit_cnt == 3'(spw_pkg::DATA_BODY_BITS - 1));
	assign char_done = bit_valid && (state == DEC_BODY) && last_bit;

	// Odd parity across this parity/flag and the previous body
	assign parity_bad = !first_char && !(^{par_bit, flag_bit, prev_body});
	assign ctrl_code  = spw_pkg::ctrl_code_e'(body_next[1:0]);

	// Shift data, cleared at each flag so control bodies stay zero-padded
	always_ff @(posedge negedge_clk)
	begin
		if (bit_valid && state == DEC_PARITY)
			par_bit <= bit_value;
		if (bit_valid && state == DEC_FLAG)
			body <= '0;
		else if (bit_valid && state == DEC_BODY)
			body <= body_next;
		if (char_done)
			prev_body <= body_next;
	end

	// ------------------------------
	// Character FSM and escape logic
	// ------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			state          <= DEC_PARITY;
			bit_cnt        <= '0;
			flag_bit       <= 1'b0;
			first_char     <= 1'b1;
			esc_pend       <= 1'b0;
			perr_hold      <= 1'b0;
			esc_err        <= 1'b0;
			chr.valid      <= 1'b0;
			chr.kind       <= spw_pkg::CHAR_DATA;
			chr.data       <= '0;
			chr.parity_err <= 1'b0;
		end
		else
		begin
			chr.valid <= 1'b0;
			esc_err   <= 1'b0;
			if (bit_valid)
			begin
				case (state)
					DEC_PARITY:
						state <= DEC_FLAG;
					DEC_FLAG:
					begin
						flag_bit <= bit_value;
						bit_cnt  <= '0;
						state    <= DEC_BODY;
					end
					DEC_BODY:
					begin
						if (last_bit)
						begin
							state      <= DEC_PARITY;
							first_char <= 1'b0;
						end
						else
							bit_cnt <= bit_cnt + 3'd1;
					end
					default:
						state <= DEC_PARITY;
				endcase
			end
			if (char_done)
			begin
				chr.data       <= body_next;
				chr.parity_err <= parity_bad | perr_hold;
				perr_hold      <= 1'b0;
				if (!flag_bit)
				begin
					// Data after ESC is a time code
					chr.valid <= 1'b1;
					chr.kind  <= esc_pend ? spw_pkg::CHAR_TIME : spw_pkg::CHAR_DATA;
					esc_pend  <= 1'b0;
				end
				else
				begin
					case (ctrl_code)
						spw_pkg::CTRL_FCT:
						begin
							chr.valid <= 1'b1;
							chr.kind  <= esc_pend ? spw_pkg::CHAR_NULL : spw_pkg::CHAR_FCT;
							esc_pend  <= 1'b0;
						end
						spw_pkg::CTRL_EOP,
						spw_pkg::CTRL_EEP:
						begin
							if (esc_pend)
							begin
								esc_err   <= 1'b1;
								esc_pend  <= 1'b0;
								perr_hold <= parity_bad | perr_hold;
							end
							else
							begin
								chr.valid <= 1'b1;
								chr.kind  <= (ctrl_code == spw_pkg::CTRL_EOP) ?
								             spw_pkg::CHAR_EOP : spw_pkg::CHAR_EEP;
							end
						end
						default:
						begin
							// Lone ESC waits; its parity result carries forward
							esc_err   <= esc_pend;
							esc_pend  <= !esc_pend;
							perr_hold <= parity_bad | perr_hold;
						end
					endcase
				end
			end
		end
	end

endmodule

// File: spw_rx_fifo.sv
`timescale 1ns/10ps

module spw_rx_fifo (
	input  logic                negedge_clk,
	input  logic                rx_resetn,
	input  logic                pop,
	input  logic                ovf_clear,
	output spw_pkg::fifo_word_t rd_data,
	output logic                empty,
	output logic                overflow,
	spw_char_if.sink            chr
);

	spw_pkg::fifo_word_t                mem [spw_pkg::FIFO_DEPTH];
	logic [spw_pkg::FIFO_ADDR_BITS:0]   wr_ptr;
	logic [spw_pkg::FIFO_ADDR_BITS:0]   rd_ptr;
	logic                               full;
	logic                               is_queued;
	logic                               push;
	spw_pkg::fifo_word_t                wr_word;

	// Extra pointer bit tells full from empty
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr == {~rd_ptr[spw_pkg::FIFO_ADDR_BITS],
	                           rd_ptr[spw_pkg::FIFO_ADDR_BITS-1:0]});

	assign is_queued = chr.kind inside {spw_pkg::CHAR_DATA, spw_pkg::CHAR_EOP,
	                                    spw_pkg::CHAR_EEP};
	assign push      = chr.valid && is_queued && !full;
	assign rd_data   = mem[rd_ptr[spw_pkg::FIFO_ADDR_BITS-1:0]];

	always_comb
	begin
		case (chr.kind)
			spw_pkg::CHAR_EOP: wr_word = '{ctrl: 1'b1, data: spw_pkg::EOP_DATA};
			spw_pkg::CHAR_EEP: wr_word = '{ctrl: 1'b1, data: spw_pkg::EEP_DATA};
			default:           wr_word = '{ctrl: 1'b0, data: chr.data};
		endcase
	end

	always_ff @(posedge negedge_clk)
	begin
		if (push)
			mem[wr_ptr[spw_pkg::FIFO_ADDR_BITS-1:0]] <= wr_word;
	end

	// ------------------------------
	// Pointers and overflow
	// ------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
			// New drop wins over a clear in the same cycle
			if (chr.valid && is_queued && full)
				overflow <= 1'b1;
			else if (ovf_clear)
				overflow <= 1'b0;
		end
	end

endmodule

// File: spw_rx_wb_slave.sv
`timescale 1ns/10ps

module spw_rx_wb_slave (
	input  logic                                negedge_clk,
	input  logic                                rx_resetn,
	input  logic                                wb_cyc,
	input  logic                                wb_stb,
	input  logic                                wb_we,
	input  logic [rx_regs_pkg::WB_ADR_BITS-1:0] wb_adr,
	input  rx_regs_pkg::wb_data_t               wb_dat_i,
	input  logic                                esc_err,
	input  spw_pkg::fifo_word_t                 rd_data,
	input  logic                                empty,
	input  logic                                overflow,
	output rx_regs_pkg::wb_data_t               wb_dat_o,
	output logic                                wb_ack,
	output logic                                pop,
	output logic                                ovf_clear,
	output logic                                rx_tick_out,
	output logic                                rx_got_fct,
	spw_char_if.sink                            chr
);

	rx_regs_pkg::reg_addr_e addr;
	logic                   access;
	logic                   rd_acc;
	logic                   st_wr;
	logic                   is_time;
	logic                   is_fct;
	logic                   got_null;
	logic                   par_flag;
	logic                   esc_flag;
	logic                   tick_pend;
	logic [7:0]             time_code;
	logic [7:0]             fct_cnt;

	assign addr    = rx_regs_pkg::reg_addr_e'(wb_adr);
	// Register side effects take place in the ack cycle
	assign access  = wb_ack && wb_cyc && wb_stb;
	assign rd_acc  = access && !wb_we;
	assign st_wr   = access && wb_we && (addr == rx_regs_pkg::REG_STATUS);
	assign is_time = chr.valid && (chr.kind == spw_pkg::CHAR_TIME);
	assign is_fct  = chr.valid && (chr.kind == spw_pkg::CHAR_FCT);

	assign pop       = rd_acc && (addr == rx_regs_pkg::REG_DATA) && !empty;
	assign ovf_clear = st_wr && wb_dat_i[rx_regs_pkg::ST_OVERFLOW];

	always_ff @(posedge negedge_clk)
	begin
		if (is_time)
			time_code <= chr.data;
	end

	// ------------------------------
	// Ack, pulses and sticky flags
	// ------------------------------
	always_ff @(posedge negedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			wb_ack      <= 1'b0;
			rx_tick_out <= 1'b0;
			rx_got_fct  <= 1'b0;
			got_null    <= 1'b0;
			par_flag    <= 1'b0;
			esc_flag    <= 1'b0;
			tick_pend   <= 1'b0;
			fct_cnt     <= '0;
		end
		else
		begin
			wb_ack      <= wb_cyc && wb_stb && !wb_ack;
			rx_tick_out <= is_time;
			rx_got_fct  <= is_fct;
			// Write-one-to-clear first, new events override
			if (st_wr)
			begin
				got_null  <= got_null & ~wb_dat_i[rx_regs_pkg::ST_GOT_NULL];
				par_flag  <= par_flag & ~wb_dat_i[rx_regs_pkg::ST_PARITY_ERR];
				esc_flag  <= esc_flag & ~wb_dat_i[rx_regs_pkg::ST_ESC_ERR];
				tick_pend <= tick_pend & ~wb_dat_i[rx_regs_pkg::ST_TICK];
			end
			if (rd_acc && addr == rx_regs_pkg::REG_TIME)
				tick_pend <= 1'b0;
			if (chr.valid && chr.kind == spw_pkg::CHAR_NULL)
				got_null <= 1'b1;
			if (chr.valid && chr.parity_err)
				par_flag <= 1'b1;
			if (esc_err)
				esc_flag <= 1'b1;
			if (is_time)
				tick_pend <= 1'b1;
			// Counter wraps at 8 bits
			if (access && wb_we && addr == rx_regs_pkg::REG_FCT)
				fct_cnt <= '0;
			else if (is_fct)
				fct_cnt <= fct_cnt + 8'd1;
		end
	end

	// Read mux
	always_comb
	begin
		wb_dat_o = '0;
		case (addr)
			rx_regs_pkg::REG_STATUS:
			begin
				wb_dat_o[rx_regs_pkg::ST_EMPTY]      = empty;
				wb_dat_o[rx_regs_pkg::ST_GOT_NULL]   = got_null;
				wb_dat_o[rx_regs_pkg::ST_PARITY_ERR] = par_flag;
				wb_dat_o[rx_regs_pkg::ST_ESC_ERR]    = esc_flag;
				wb_dat_o[rx_regs_pkg::ST_OVERFLOW]   = overflow;
				wb_dat_o[rx_regs_pkg::ST_TICK]       = tick_pend;
			end
			rx_regs_pkg::REG_DATA:
			begin
				wb_dat_o[8:0]                         = rd_data;
				wb_dat_o[rx_regs_pkg::DATA_EMPTY_BIT] = empty;
			end
			rx_regs_pkg::REG_TIME:
				wb_dat_o[7:0] = time_code;
			default:
				wb_dat_o[7:0] = fct_cnt;
		endcase
	end

endmodule

// File: spw_rx_top.sv
`timescale 1ns/10ps

module spw_rx_top (
	input  logic                                negedge_clk,
	input  logic                                rx_resetn,
	input  logic                                rx_din,
	input  logic                                rx_sin,
	input  logic                                wb_cyc,
	input  logic                                wb_stb,
	input  logic                                wb_we,
	input  logic [rx_regs_pkg::WB_ADR_BITS-1:0] wb_adr,
	input  rx_regs_pkg::wb_data_t               wb_dat_i,
	output rx_regs_pkg::wb_data_t               wb_dat_o,
	output logic                                wb_ack,
	output logic                                rx_tick_out,
	output logic                                rx_got_fct
);

	logic                bit_valid;
	logic                bit_value;
	logic                esc_err;
	logic                pop;
	logic                ovf_clear;
	logic                empty;
	logic                overflow;
	spw_pkg::fifo_word_t rd_data;

	// Decoded character stream shared by FIFO and register block
	spw_char_if chr ();

	spw_ds_bit_recovery i_bit_rec (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.bit_valid   (bit_valid),
		.bit_value   (bit_value)
	);

	spw_char_decoder i_decoder (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.bit_valid   (bit_valid),
		.bit_value   (bit_value),
		.esc_err     (esc_err),
		.chr         (chr.dec)
	);

	spw_rx_fifo i_fifo (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.pop         (pop),
		.ovf_clear   (ovf_clear),
		.rd_data     (rd_data),
		.empty       (empty),
		.overflow    (overflow),
		.chr         (chr.sink)
	);

	spw_rx_wb_slave i_wb_slave (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_i    (wb_dat_i),
		.esc_err     (esc_err),
		.rd_data     (rd_data),
		.empty       (empty),
		.overflow    (overflow),
		.wb_dat_o    (wb_dat_o),
		.wb_ack      (wb_ack),
		.pop         (pop),
		.ovf_clear   (ovf_clear),
		.rx_tick_out (rx_tick_out),
		.rx_got_fct  (rx_got_fct),
		.chr         (chr.sink)
	);

endmodule

// File: tb_spw_rx.sv
`timescale 1ns/10ps

module tb_spw_rx;

	localparam int WB_TIMEOUT    = 20;
	localparam int PULSE_TIMEOUT = 200;
	// Bit recovery, decoder and sink stages plus margin
	localparam int LINE_SETTLE   = 4;
	localparam int QUIET_CYCLES  = 12;

	logic                        negedge_clk;
	logic                        rx_resetn;
	logic                        rx_din;
	logic                        rx_sin;
	logic                        wb_cyc;
	logic                        wb_stb;
	logic                        wb_we;
	logic [1:0]                  wb_adr;
	rx_regs_pkg::wb_data_t       wb_dat_i;
	rx_regs_pkg::wb_data_t       wb_dat_o;
	logic                        wb_ack;
	logic                        rx_tick_out;
	logic                        rx_got_fct;

	// Encoder line state and previous body for parity
	logic                        line_d;
	logic                        line_s;
	logic [7:0]                  prev_body;

	int                          seed = 40942;
	int                          n_tests = 0;
	int                          n_checks = 0;
	int                          n_errors = 0;
	int                          test_err_base = 0;
	logic                        timed_out = 1'b0;
	int                          tick_seen = 0;
	int                          fct_seen = 0;
	int                          tick_mark = 0;
	int                          fct_mark = 0;

	spw_rx_top i_dut (
		.negedge_clk (negedge_clk),
		.rx_resetn   (rx_resetn),
		.rx_din      (rx_din),
		.rx_sin      (rx_sin),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack      (wb_ack),
		.rx_tick_out (rx_tick_out),
		.rx_got_fct  (rx_got_fct)
	);

	initial
	begin
		negedge_clk = 1'b0;
		forever #10 negedge_clk = ~negedge_clk;
	end

	// Pulse counters
	always @(posedge negedge_clk)
	begin
		if (rx_tick_out)
			tick_seen <= tick_seen + 1;
		if (rx_got_fct)
			fct_seen <= fct_seen + 1;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic fail_timeout(input string what);
		timed_out = 1'b1;
		$display("Timeout at %0t ns while waiting for %s", $time, what);
		$display("Simulation FAILED");
		$finish;
	endtask

	function automatic rx_regs_pkg::wb_data_t status_bit(input int pos);
		rx_regs_pkg::wb_data_t w;
		w      = '0;
		w[pos] = 1'b1;
		return w;
	endfunction

	function automatic spw_pkg::fifo_word_t pack_word(input logic ctrl, input logic [7:0] data);
		spw_pkg::fifo_word_t w;
		w.ctrl = ctrl;
		w.data = data;
		return w;
	endfunction

	function automatic logic [7:0] random_byte();
		int rnd;
		rnd = $random(seed);
		return rnd[7:0];
	endfunction

	task automatic start_test();
		test_err_base = n_errors;
		n_tests++;
	endtask

	task automatic report_test(input string name);
		$display("Test %0d %s finished with %0d error(s)", n_tests, name,
		         n_errors - test_err_base);
	endtask

	// ------------------------------
	// Data/strobe encoder
	// ------------------------------
	task automatic send_bit(input logic b);
		@(posedge negedge_clk);
		// Strobe toggles only when data repeats
		if (b == line_d)
			line_s = ~line_s;
		line_d = b;
		rx_din <= line_d;
		rx_sin <= line_s;
		repeat (3) @(posedge negedge_clk);
	endtask

	task automatic send_char(input logic flag, input logic [7:0] body, input logic corrupt);
		int   nbits;
		int   i;
		logic par;
		nbits = flag ? 2 : 8;
		// Ones in parity, flag and previous body must be odd
		par = 1'b1 ^ flag ^ (^prev_body);
		if (corrupt)
			par = ~par;
		send_bit(par);
		send_bit(flag);
		for (i = 0; i < nbits; i++)
			send_bit(body[i]);
		prev_body = flag ? {6'b0, body[1:0]} : body;
	endtask

	task automatic send_ctrl(input spw_pkg::ctrl_code_e code, input logic corrupt);
		send_char(1'b1, {6'b0, code}, corrupt);
	endtask

	task automatic send_data(input logic [7:0] b);
		send_char(1'b0, b, 1'b0);
	endtask

	task automatic settle_line();
		repeat (LINE_SETTLE) @(posedge negedge_clk);
	endtask

	// ------------------------------
	// Wishbone host
	// ------------------------------
	task automatic wb_read(input rx_regs_pkg::reg_addr_e addr,
	                       output rx_regs_pkg::wb_data_t data);
		int n;
		n    = 0;
		data = '0;
		@(posedge negedge_clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b0;
		wb_adr <= addr;
		@(posedge negedge_clk);
		while (!wb_ack && n < WB_TIMEOUT)
		begin
			@(posedge negedge_clk);
			n++;
		end
		if (!wb_ack)
			fail_timeout("wb_ack on a read");
		else
		begin
			// Edge closing the ack cycle
			data = wb_dat_o;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
		end
	endtask

	task automatic wb_write(input rx_regs_pkg::reg_addr_e addr,
	                        input rx_regs_pkg::wb_data_t data);
		int n;
		n = 0;
		@(posedge negedge_clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_adr   <= addr;
		wb_dat_i <= data;
		@(posedge negedge_clk);
		while (!wb_ack && n < WB_TIMEOUT)
		begin
			@(posedge negedge_clk);
			n++;
		end
		if (!wb_ack)
			fail_timeout("wb_ack on a write");
		else
		begin
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
		end
	endtask

	// ------------------------------
	// Checks
	// ------------------------------
	task automatic check_fifo_word(input string what, input spw_pkg::fifo_word_t got,
	                               input spw_pkg::fifo_word_t exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("FAILED at %0t ns: %s got ctrl=%b data=%h, expected ctrl=%b data=%h",
			         $time, what, got.ctrl, got.data, exp.ctrl, exp.data);
		end
	endtask

	task automatic check_reg(input string what, input rx_regs_pkg::wb_data_t got,
	                         input rx_regs_pkg::wb_data_t exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("FAILED at %0t ns: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic mark_pulses();
		tick_mark = tick_seen;
		fct_mark  = fct_seen;
	endtask

	task automatic check_pulse(input string what, input int exp_tick, input int exp_fct);
		int n;
		n = 0;
		while ((tick_seen - tick_mark < exp_tick || fct_seen - fct_mark < exp_fct) &&
		       n < PULSE_TIMEOUT)
		begin
			@(posedge negedge_clk);
			n++;
		end
		if (tick_seen - tick_mark < exp_tick || fct_seen - fct_mark < exp_fct)
			fail_timeout(what);
		else
		begin
			// Quiet window catches any extra pulse
			repeat (QUIET_CYCLES) @(posedge negedge_clk);
			n_checks++;
			if (tick_seen - tick_mark != exp_tick || fct_seen - fct_mark != exp_fct)
			begin
				n_errors++;
				$display("FAILED at %0t ns: %s got %0d/%0d tick/fct pulses, expected %0d/%0d",
				         $time, what, tick_seen - tick_mark, fct_seen - fct_mark,
				         exp_tick, exp_fct);
			end
		end
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic test_reset_state();
		rx_regs_pkg::wb_data_t rd;
		start_test();
		mark_pulses();
		wb_read(rx_regs_pkg::REG_STATUS, rd);
		check_reg("status after reset", rd, status_bit(rx_regs_pkg::ST_EMPTY));
		wb_read(rx_regs_pkg::REG_FCT, rd);
		check_reg("fct count after reset", rd, '0);
		check_pulse("pulses after reset", 0, 0);
		report_test("reset_state");
	endtask

	task automatic test_packet_path();
		rx_regs_pkg::wb_data_t rd;
		spw_pkg::fifo_word_t   exp_q[$];
		logic [7:0]            b;
		int                    i;
		start_test();
		send_ctrl(spw_pkg::CTRL_ESC, 1'b0);
		send_ctrl(spw_pkg::CTRL_FCT, 1'b0);
		for (i = 0; i < 3; i++)
		begin
			b = random_byte();
			send_data(b);
			exp_q.push_back(pack_word(1'b0, b));
		end
		send_ctrl(spw_pkg::CTRL_EOP, 1'b0);
		exp_q.push_back(pack_word(1'b1, 8'h00));
		for (i = 0; i < 2; i++)
		begin
			b = random_byte();
			send_data(b);
			exp_q.push_back(pack_word(1'b0, b));
		end
		send_ctrl(spw_pkg::CTRL_EEP, 1'b0);
		exp_q.push_back(pack_word(1'b1, 8'h01));
		settle_line();
		wb_read(rx_regs_pkg::REG_STATUS, rd);
		check_reg("status after packet", rd, status_bit(rx_regs_pkg::ST_GOT_NULL));
		while (exp_q.size() > 0)
		begin
			wb_read(rx_regs_pkg::REG_DATA, rd);
			check_fifo_word("packet word", spw_pkg::fifo_word_t'(rd[8:0]), exp_q.pop_front());
		end
		wb_read(rx_regs_pkg::REG_DATA, rd);
		check_reg("data empty bit", rd & status_bit(31), status_bit(31));
		wb_write(rx_regs_pkg::REG_STATUS, status_bit(rx_regs_pkg::ST_GOT_NULL));
		report_test("packet_path");
	endtask

	task automatic test_time_code();
		rx_regs_pkg::wb_data_t rd;
		logic [7:0]            tc;
		start_test();
		tc = random_byte();
		mark_pulses();
		send_ctrl(spw_pkg::CTRL_ESC, 1'b0);
		send_data(tc);
		check_pulse("time code pulse", 1, 0);
		wb_read(rx_regs_pkg::REG_STATUS, rd);
		check_reg("status with tick", rd,
		          status_bit(rx_regs_pkg::ST_EMPTY) | status_bit(rx_regs_pkg::ST_TICK));
		wb_read(rx_regs_pkg::REG_TIME, rd);
		check_reg("time code", rd, {24'b0, tc});
		wb_read(rx_regs_pkg::REG_STATUS, rd);
		check_reg("status after time read", rd, status_bit(rx_regs_pkg::ST_EMPTY));
		report_test("time_code");
	endtask

	task automatic test_flow_control();
		rx_regs_pkg::wb_data_t rd;
		int                    i;
		start_test();
		mark_pulses();
		for (i = 0; i < 5; i++)
			send_ctrl(spw_pkg::CTRL_FCT, 1'b0);
		check_pulse("fct pulses", 0, 5);
		wb_read(rx_regs_pkg::REG_FCT, rd);
		check_reg("fct count", rd, 32'd5);
		wb_write(rx_regs_pkg::REG_FCT, '0);
		wb_read(rx_regs_pkg::REG_FCT, rd);
		check_reg("fct count after clear", rd, '0);
		report_test("flow_control");
	endtask

	task automatic test_errors();
		rx_regs_pkg::wb_data_t rd;
		rx_regs_pkg::wb_data_t err_bits;
		start_test();
		err_bits = status_bit(rx_regs_pkg::ST_PARITY_ERR) | status_bit(rx_regs_pkg::ST_ESC_ERR);
		send_ctrl(spw_pkg::CTRL_FCT, 1'b1);
		send_ctrl(spw_pkg::CTRL_ESC, 1'b0);
		send_ctrl(spw_pkg::CTRL_EOP, 1'b0);
		settle_line();
		wb_read(rx_regs_pkg::REG_STATUS, rd);
		check_reg("status with errors", rd, status_bit(rx_regs_pkg::ST_EMPTY) | err_bits);
		wb_write(rx_regs_pkg::REG_STATUS, err_bits);
		wb_read(rx_regs_pkg::REG_STATUS, rd);
		check_reg("status after clear", rd, status_bit(rx_regs_pkg::ST_EMPTY));
		report_test("errors");
	endtask

	task automatic test_overflow();
		rx_regs_pkg::wb_data_t rd;
		spw_pkg::fifo_word_t   exp_q[$];
		logic [7:0]            b;
		int                    i;
		start_test();
		for (i = 0; i < 10; i++)
		begin
			b = random_byte();
			send_data(b);
			// Only the first FIFO_DEPTH bytes fit
			if (i < (1 << spw_pkg::FIFO_ADDR_BITS))
				exp_q.push_back(pack_word(1'b0, b));
		end
		settle_line();
		wb_read(rx_regs_pkg::REG_STATUS, rd);
		check_reg("status with overflow", rd, status_bit(rx_regs_pkg::ST_OVERFLOW));
		while (exp_q.size() > 0)
		begin
			wb_read(rx_regs_pkg::REG_DATA, rd);
			check_fifo_word("kept word", spw_pkg::fifo_word_t'(rd[8:0]), exp_q.pop_front());
		end
		wb_read(rx_regs_pkg::REG_DATA, rd);
		check_reg("data empty bit", rd & status_bit(31), status_bit(31));
		wb_write(rx_regs_pkg::REG_STATUS, status_bit(rx_regs_pkg::ST_OVERFLOW));
		wb_read(rx_regs_pkg::REG_STATUS, rd);
		check_reg("status after overflow clear", rd, status_bit(rx_regs_pkg::ST_EMPTY));
		report_test("overflow");
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial
	begin
		rx_resetn = 1'b0;
		rx_din    = 1'b0;
		rx_sin    = 1'b0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat_i  = '0;
		line_d    = 1'b0;
		line_s    = 1'b0;
		prev_body = '0;
		repeat (16) @(posedge negedge_clk);
		rx_resetn <= 1'b1;

		test_reset_state();
		test_packet_path();
		test_time_code();
		test_flow_control();
		test_errors();
		test_overflow();

		if (!timed_out)
		begin
			$display("Tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
			if (n_errors == 0)
				$display("Simulation PASSED");
			else
				$display("Simulation FAILED");
			$finish;
		end
	end

endmodule

// File: all.f
spw_pkg.sv
rx_regs_pkg.sv
spw_char_if.sv
spw_ds_bit_recovery.sv
spw_char_decoder.sv
spw_rx_fifo.sv
spw_rx_wb_slave.sv
spw_rx_top.sv
tb_spw_rx.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_spw_rx
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
